/* design/vec_types_pkg.sv */
// Register file geometry and write-request types; SEW encoding 2'b11 is unused and never written.
`default_nettype none

package vec_types_pkg;

  localparam int VLENB     = 8;                    // Bytes per vector register.
  localparam int NUM_VREGS = 32;                   // Architectural vector registers.
  localparam int REG_IDX_W = $clog2(NUM_VREGS);    // Register index width.
  localparam int ELEM_W    = 32;                   // Widest element slot.

  typedef logic [7:0] byte_t;                      // One register byte.
  typedef byte_t [VLENB-1:0] vreg_t;               // Whole register, byte 0 lowest.
  typedef logic [REG_IDX_W-1:0] vreg_idx_t;        // Register number.
  typedef logic [ELEM_W-1:0] elem_t;               // Element slot, low SEW bits valid.

  // Element width of one write; both elements share it.
  typedef enum logic [1:0] {
    SEW_8  = 2'b00,                                // Two bytes written.
    SEW_16 = 2'b01,                                // Four bytes written.
    SEW_32 = 2'b10                                 // All eight bytes written.
  } sew_t;

  typedef struct packed {
    elem_t e1;                                     // Upper element of the span.
    elem_t e0;                                     // Lower element of the span.
  } elem_pair_t;

  // One pending register write, 71 bits.
  typedef struct packed {
    vreg_idx_t  vd;                                // Destination register.
    sew_t       sew;                               // Element width.
    elem_pair_t elems;                             // Zero-extended elements.
  } wb_req_t;

  // Keeps the low SEW bits of an element slot.
  function automatic elem_t sew_mask(sew_t s);
    elem_t m;
    case (s)
      SEW_8:   m = 32'h0000_00ff;                  // Byte elements.
      SEW_16:  m = 32'h0000_ffff;                  // Halfword elements.
      SEW_32:  m = 32'hffff_ffff;                  // Word elements.
      default: m = '0;                             // Unused code clears all.
    endcase
    return m;
  endfunction

  // Applies the SEW mask to both elements of a pair.
  function automatic elem_pair_t sew_trunc(elem_pair_t p, sew_t s);
    elem_pair_t t;
    t.e1 = p.e1 & sew_mask(s);                     // Upper element.
    t.e0 = p.e0 & sew_mask(s);                     // Lower element.
    return t;
  endfunction

endpackage

`default_nettype wire

/* design/valu_ops_pkg.sv */
// ALU command and unit state types; only four logic/arith ops, no multiply or masking.
`default_nettype none

package valu_ops_pkg;
  import vec_types_pkg::*;

  // Element-wise operation of the vector ALU.
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,                                // vd = vs1 + vs2.
    OP_SUB = 2'b01,                                // vd = vs1 - vs2.
    OP_AND = 2'b10,                                // vd = vs1 & vs2.
    OP_XOR = 2'b11                                 // vd = vs1 ^ vs2.
  } valu_op_t;

  // One ALU command as presented with its strobe.
  typedef struct packed {
    valu_op_t  op;                                 // Operation.
    vreg_idx_t vd;                                 // Destination register.
    vreg_idx_t vs1;                                // First source.
    vreg_idx_t vs2;                                // Second source.
    sew_t      sew;                                // Element width.
  } valu_cmd_t;

  // Peer unit FSM, shared by the ALU and load units.
  typedef enum logic {
    IDLE       = 1'b0,                             // Free, accepts a strobe.
    WAIT_GRANT = 1'b1                              // Result held for the write port.
  } unit_state_t;

endpackage

`default_nettype wire

/* design/vec_reg_file.sv */
// One SEW-decoded write port, two async reads; a write to a register being read shows next cycle.
`timescale 1ns/1ps
`default_nettype none

module vec_reg_file
  import vec_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      wen,
  input  wb_req_t   wreq,
  input  vreg_idx_t rs1,
  input  vreg_idx_t rs2,
  output vreg_t     rs1_data,
  output vreg_t     rs2_data
);

  vreg_t [NUM_VREGS-1:0] regs;                     // Register storage.
  elem_t                 e0;                       // Lower element of the write.
  elem_t                 e1;                       // Upper element of the write.

  assign e0 = wreq.elems.e0;
  assign e1 = wreq.elems.e1;

  // Byte span follows SEW, bytes above the span hold.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      regs <= '0;                                  // All registers read zero.
    end else if (wen) begin
      case (wreq.sew)
        SEW_32: begin
          regs[wreq.vd][7:4] <= e1;                // Bytes 7..4.
          regs[wreq.vd][3:0] <= e0;                // Bytes 3..0.
        end
        SEW_16: begin
          regs[wreq.vd][3:2] <= e1[15:0];          // Bytes 3..2.
          regs[wreq.vd][1:0] <= e0[15:0];          // Bytes 1..0.
        end
        SEW_8: begin
          regs[wreq.vd][1] <= e1[7:0];             // Byte 1.
          regs[wreq.vd][0] <= e0[7:0];             // Byte 0.
        end
        default: begin
          regs[wreq.vd] <= regs[wreq.vd];          // Unused code writes nothing.
        end
      endcase
    end
  end

  // Combinational reads for the ALU operands.
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* design/vec_wb_arbiter.sv */
// Two-way round-robin on the write port; grant is combinational, the ALU wins the first tie.
`timescale 1ns/1ps
`default_nettype none

module vec_wb_arbiter
  import vec_types_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    alu_req,
  input  logic    load_req,
  input  wb_req_t alu_wreq,
  input  wb_req_t load_wreq,
  output logic    alu_gnt,
  output logic    load_gnt,
  output logic    wen,
  output wb_req_t wreq,
  output logic    wb_src
);

  logic last_load;                                 // Load unit won the last write.
  logic pick_load;                                 // Load unit wins this cycle.

  // Load wins alone, or on a tie after an ALU win.
  always_comb begin
    pick_load = load_req & (~alu_req | ~last_load);
  end

  assign alu_gnt  = alu_req & ~pick_load;          // ALU alone, or its turn.
  assign load_gnt = pick_load;                     // Single-cycle, request drops after.
  assign wen      = alu_req | load_req;            // Some peer always wins.
  assign wb_src   = pick_load;                     // 0 = ALU, 1 = load.

  // Winning request drives the write port and the commit trace.
  always_comb begin
    if (pick_load) begin
      wreq = load_wreq;
    end else begin
      wreq = alu_wreq;
    end
  end

  // Remembers the last winner for the next tie.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      last_load <= 1'b1;                           // ALU favored after reset.
    end else if (wen) begin
      last_load <= pick_load;
    end
  end

endmodule

`default_nettype wire

/* design/vec_alu_unit.sv */
// Operands read in the strobe cycle; only the low two elements of each source are used.
`timescale 1ns/1ps
`default_nettype none

module vec_alu_unit
  import vec_types_pkg::*;
  import valu_ops_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      strobe,
  input  valu_cmd_t cmd,
  output vreg_idx_t vs1,
  output vreg_idx_t vs2,
  input  vreg_t     rs1_data,
  input  vreg_t     rs2_data,
  input  logic      gnt,
  output logic      req,
  output wb_req_t   wreq,
  output logic      busy
);

  unit_state_t state;                              // Unit FSM.
  elem_pair_t  res;                                // Results of this cycle's operands.
  logic        accept;                             // Strobe taken this cycle.

  // Picks element idx of width SEW from the low bytes, zero-extended.
  function automatic elem_t get_elem(vreg_t v, sew_t s, int unsigned idx);
    logic [8*VLENB-1:0] flat;
    elem_t              e;
    flat = v;
    e    = '0;
    case (s)
      SEW_8:   e[7:0]  = flat[idx*8 +: 8];         // Byte idx.
      SEW_16:  e[15:0] = flat[idx*16 +: 16];       // Halfword idx.
      SEW_32:  e       = flat[idx*32 +: 32];       // Word idx.
      default: e       = '0;
    endcase
    return e;
  endfunction

  // One element of the operation, wrapped to SEW by the mask.
  function automatic elem_t alu_op(valu_op_t op, elem_t a, elem_t b, sew_t s);
    elem_t r;
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;                          // Borrow drops with the mask.
      OP_AND:  r = a & b;
      OP_XOR:  r = a ^ b;
      default: r = '0;
    endcase
    return r & sew_mask(s);
  endfunction

  assign vs1 = cmd.vs1;                            // Read ports follow the command.
  assign vs2 = cmd.vs2;

  always_comb begin
    res.e0 = alu_op(cmd.op, get_elem(rs1_data, cmd.sew, 0),
                    get_elem(rs2_data, cmd.sew, 0), cmd.sew);
    res.e1 = alu_op(cmd.op, get_elem(rs1_data, cmd.sew, 1),
                    get_elem(rs2_data, cmd.sew, 1), cmd.sew);
  end

  assign accept = strobe & (state == IDLE);        // Strobes while busy are lost.
  assign req    = (state == WAIT_GRANT);
  assign busy   = (state == WAIT_GRANT);

  // FSM. Grant in WAIT_GRANT frees the unit at the next edge.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else if (accept) begin
      state <= WAIT_GRANT;
    end else if ((state == WAIT_GRANT) && gnt) begin
      state <= IDLE;
    end
  end

  // Result held until the write port takes it.
  always_ff @(posedge CLK) begin
    if (accept) begin
      wreq.vd    <= cmd.vd;
      wreq.sew   <= cmd.sew;
      wreq.elems <= res;
    end
  end

endmodule

`default_nettype wire

/* design/vec_load_unit.sv */
// No addressing; the element pair arrives with the strobe and is cut to SEW on capture.
`timescale 1ns/1ps
`default_nettype none

module vec_load_unit
  import vec_types_pkg::*;
  import valu_ops_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       strobe,
  input  vreg_idx_t  vd,
  input  sew_t       sew,
  input  elem_pair_t elems,
  input  logic       gnt,
  output logic       req,
  output wb_req_t    wreq,
  output logic       busy
);

  unit_state_t state;                              // Unit FSM.
  logic        accept;                             // Strobe taken this cycle.

  assign accept = strobe & (state == IDLE);        // Ignored while waiting.
  assign req    = (state == WAIT_GRANT);
  assign busy   = (state == WAIT_GRANT);

  // FSM. A grant releases the unit.
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else if (accept) begin
      state <= WAIT_GRANT;
    end else if ((state == WAIT_GRANT) && gnt) begin
      state <= IDLE;
    end
  end

  // Load data captured, bits above SEW cleared.
  always_ff @(posedge CLK) begin
    if (accept) begin
      wreq.vd    <= vd;
      wreq.sew   <= sew;
      wreq.elems <= sew_trunc(elems, sew);
    end
  end

endmodule

`default_nettype wire

/* design/vec_lane_top.sv */
// Lane top; wb_req is only meaningful while wb_valid is high, and strobes during busy are dropped.
`timescale 1ns/1ps
`default_nettype none

module vec_lane_top
  import vec_types_pkg::*;
  import valu_ops_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       alu_strobe,
  input  valu_cmd_t  alu_cmd,
  input  logic       load_strobe,
  input  vreg_idx_t  load_vd,
  input  sew_t       load_sew,
  input  elem_pair_t load_elems,
  output logic       alu_busy,
  output logic       load_busy,
  output logic       wb_valid,
  output logic       wb_src,
  output wb_req_t    wb_req
);

  logic      alu_req;                              // ALU holds a result.
  logic      load_req;                             // Load unit holds data.
  wb_req_t   alu_wreq;                             // ALU pending write.
  wb_req_t   load_wreq;                            // Load pending write.
  logic      alu_gnt;                              // ALU wins the port.
  logic      load_gnt;                             // Load wins the port.
  vreg_idx_t vs1;                                  // ALU read index 1.
  vreg_idx_t vs2;                                  // ALU read index 2.
  vreg_t     rs1_data;                             // ALU operand 1.
  vreg_t     rs2_data;                             // ALU operand 2.

  // Granted write doubles as the commit trace.
  vec_reg_file i_rf (
    .CLK      (CLK),
    .nRST     (nRST),
    .wen      (wb_valid),
    .wreq     (wb_req),
    .rs1      (vs1),
    .rs2      (vs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  vec_wb_arbiter i_arb (
    .CLK       (CLK),
    .nRST      (nRST),
    .alu_req   (alu_req),
    .load_req  (load_req),
    .alu_wreq  (alu_wreq),
    .load_wreq (load_wreq),
    .alu_gnt   (alu_gnt),
    .load_gnt  (load_gnt),
    .wen       (wb_valid),
    .wreq      (wb_req),
    .wb_src    (wb_src)
  );

  vec_alu_unit i_alu (
    .CLK (CLK), .nRST (nRST), .strobe (alu_strobe), .cmd (alu_cmd),
    .vs1 (vs1), .vs2 (vs2), .rs1_data (rs1_data), .rs2_data (rs2_data),
    .gnt (alu_gnt), .req (alu_req), .wreq (alu_wreq), .busy (alu_busy)
  );

  vec_load_unit i_load (
    .CLK (CLK), .nRST (nRST), .strobe (load_strobe), .vd (load_vd),
    .sew (load_sew), .elems (load_elems), .gnt (load_gnt),
    .req (load_req), .wreq (load_wreq), .busy (load_busy)
  );

endmodule

`default_nettype wire

/* tests/vec_lane_model.svh */
// Expected register file and ALU elements; assumes SEW codes 0..2 only and two elements per write.
`ifndef VEC_LANE_MODEL_SVH
`define VEC_LANE_MODEL_SVH

vreg_t model_regs [NUM_VREGS];                     // Expected register contents.

// Bytes in one element of the given width.
function automatic int elem_bytes(sew_t s);
  case (s)
    SEW_8:   return 1;
    SEW_16:  return 2;
    default: return 4;                             // SEW_32.
  endcase
endfunction

// Keeps the low SEW bits, clears the rest.
function automatic elem_t elem_keep(elem_t v, sew_t s);
  elem_t r;
  r = '0;
  for (int i = 0; i < 8 * elem_bytes(s); i++) begin
    r[i] = v[i];
  end
  return r;
endfunction

// Element idx of a register, zero-extended.
function automatic elem_t model_elem(vreg_t v, sew_t s, int idx);
  elem_t e;
  int    n;
  n = elem_bytes(s);
  e = '0;
  for (int k = 0; k < n; k++) begin
    e[8*k +: 8] = v[idx*n + k];                    // Byte k of the element.
  end
  return e;
endfunction

// One element result, wrapped at SEW.
function automatic elem_t model_alu(valu_op_t op, elem_t a, elem_t b, sew_t s);
  elem_t r;
  case (op)
    OP_ADD:  r = a + b;
    OP_SUB:  r = a - b;
    OP_AND:  r = a & b;
    default: r = a ^ b;                            // OP_XOR.
  endcase
  return elem_keep(r, s);
endfunction

// Write request that an ALU command produces from the current model state.
function automatic wb_req_t expect_alu(valu_cmd_t c);
  wb_req_t w;
  w.vd       = c.vd;
  w.sew      = c.sew;
  w.elems.e0 = model_alu(c.op, model_elem(model_regs[c.vs1], c.sew, 0),
                         model_elem(model_regs[c.vs2], c.sew, 0), c.sew);
  w.elems.e1 = model_alu(c.op, model_elem(model_regs[c.vs1], c.sew, 1),
                         model_elem(model_regs[c.vs2], c.sew, 1), c.sew);
  return w;
endfunction

// Write request of a load, elements cut to SEW.
function automatic wb_req_t expect_load(vreg_idx_t vd, sew_t s, elem_pair_t el);
  wb_req_t w;
  w.vd       = vd;
  w.sew      = s;
  w.elems.e0 = elem_keep(el.e0, s);
  w.elems.e1 = elem_keep(el.e1, s);
  return w;
endfunction

// SEW-masked write, bytes above the span keep their value.
function automatic void model_write(wb_req_t w);
  int    n;
  elem_t e;
  n = elem_bytes(w.sew);
  for (int b = 0; b < 2 * n; b++) begin
    e = (b < n) ? w.elems.e0 : w.elems.e1;         // Low half is e0.
    model_regs[w.vd][b] = e[8*(b % n) +: 8];
  end
endfunction

`endif

/* tests/vec_lane_tb.sv */
// Lane testbench; one pending write per unit, stimulus from a fixed-seed LFSR, stops at first error.
`timescale 1ns/1ps
`default_nettype none

module vec_lane_tb
  import vec_types_pkg::*;
  import valu_ops_pkg::*;
();

  localparam int CLK_PERIOD = 4;                   // ns.
  localparam int RAND_OPS   = 600;                 // Random cycles.
  localparam int NUM_OPS    = RAND_OPS + 200;      // Directed cycles stay under 200.
  localparam int WDOG_CYC   = NUM_OPS * 4 + 50;    // Watchdog limit in cycles.

  logic       CLK;
  logic       nRST;
  logic       alu_strobe;
  valu_cmd_t  alu_cmd;
  logic       load_strobe;
  vreg_idx_t  load_vd;
  sew_t       load_sew;
  elem_pair_t load_elems;
  logic       alu_busy;
  logic       load_busy;
  logic       wb_valid;
  logic       wb_src;
  wb_req_t    wb_req;

  wb_req_t     alu_q[$];                           // Expected ALU writes.
  wb_req_t     load_q[$];                          // Expected load writes.
  logic        last_load;                          // Load won the last write.
  logic [31:0] lfsr;                               // Random state.

  `include "vec_lane_model.svh"

  vec_lane_top i_dut (
    .CLK (CLK), .nRST (nRST), .alu_strobe (alu_strobe), .alu_cmd (alu_cmd),
    .load_strobe (load_strobe), .load_vd (load_vd), .load_sew (load_sew),
    .load_elems (load_elems), .alu_busy (alu_busy), .load_busy (load_busy),
    .wb_valid (wb_valid), .wb_src (wb_src), .wb_req (wb_req)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WDOG_CYC * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WDOG_CYC);
    $display("CHECKS FAILED");
    $fatal(1);
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);                      // One step per bit.
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic sew_t pick_sew();
    case (take_bits(2) % 3)
      0:       return SEW_8;
      1:       return SEW_16;
      default: return SEW_32;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [127:0] got,
                          input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // One cycle: check the commit, drive strobes, then retire the write into the model.
  task automatic step(input logic a_go, input valu_cmd_t a_cmd, input logic l_go,
                      input vreg_idx_t l_vd, input sew_t l_sew, input elem_pair_t l_el);
    logic    a_req;
    logic    l_req;
    logic    exp_src;
    wb_req_t exp_wr;
    @(posedge CLK);
    #1;
    a_req   = (alu_q.size() != 0);                 // Queued writes are the live requests.
    l_req   = (load_q.size() != 0);
    if (a_req && l_req) begin
      exp_src = ~last_load;                        // Peer not granted last time wins.
    end else begin
      exp_src = l_req;                             // A lone request is granted.
    end
    exp_wr  = '0;
    check_eq("alu_busy", alu_busy, a_req);
    check_eq("load_busy", load_busy, l_req);
    check_eq("wb_valid", wb_valid, a_req | l_req);
    if (a_req | l_req) begin
      check_eq("wb_src", wb_src, exp_src);
      exp_wr = exp_src ? load_q.pop_front() : alu_q.pop_front();
      check_eq("wb_req", wb_req, exp_wr);
      last_load = exp_src;
    end
    alu_strobe  = a_go & ~a_req;                   // No strobe while busy.
    alu_cmd     = a_cmd;
    load_strobe = l_go & ~l_req;
    load_vd     = l_vd;
    load_sew    = l_sew;
    load_elems  = l_el;
    if (alu_strobe) alu_q.push_back(expect_alu(a_cmd));   // Reads before this commit.
    if (load_strobe) load_q.push_back(expect_load(l_vd, l_sew, l_el));
    if (a_req | l_req) model_write(exp_wr);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, '0, 1'b0, '0, SEW_8, '0);
  endtask

  task automatic issue_alu(input valu_op_t op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input sew_t s);
    valu_cmd_t c;
    c = '{op: op, vd: vd, vs1: vs1, vs2: vs2, sew: s};
    step(1'b1, c, 1'b0, '0, SEW_8, '0);
    idle(2);
  endtask

  task automatic issue_load(input vreg_idx_t vd, input sew_t s, input elem_t e1,
                            input elem_t e0);
    step(1'b0, '0, 1'b1, vd, s, '{e1: e1, e0: e0});
    idle(2);
  endtask

  // Both units in one cycle, the loser commits a cycle later.
  task automatic issue_both(input valu_op_t op, input vreg_idx_t vd, input vreg_idx_t ld_vd);
    valu_cmd_t c;
    c = '{op: op, vd: vd, vs1: 5'd1, vs2: 5'd7, sew: SEW_16};
    step(1'b1, c, 1'b1, ld_vd, SEW_32, '{e1: 32'hcafe_f00d, e0: 32'h0bad_beef});
    idle(3);
  endtask

  task automatic run_random(input int n);
    valu_cmd_t  c;
    elem_pair_t el;
    logic       a_go;
    logic       l_go;
    vreg_idx_t  l_vd;
    sew_t       l_sew;
    repeat (n) begin
      a_go  = 1'(take_bits(1));
      l_go  = 1'(take_bits(1));
      c.op  = valu_op_t'(take_bits(2) & 32'h3);
      c.vd  = vreg_idx_t'(take_bits(4));           // 16 registers for more reuse.
      c.vs1 = vreg_idx_t'(take_bits(4));
      c.vs2 = vreg_idx_t'(take_bits(4));
      c.sew = pick_sew();
      l_vd  = vreg_idx_t'(take_bits(4));
      l_sew = pick_sew();
      el.e1 = take_bits(32);
      el.e0 = take_bits(32);
      step(a_go, c, l_go, l_vd, l_sew, el);
    end
  endtask

  initial begin
    lfsr        = 32'hc100;
    last_load   = 1'b1;                            // ALU takes the first tie.
    nRST        = 1'b0;
    alu_strobe  = 1'b0;
    alu_cmd     = '0;
    load_strobe = 1'b0;
    load_vd     = '0;
    load_sew    = SEW_8;
    load_elems  = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;
    idle(2);                                       // Quiet after reset.
    issue_both(OP_ADD, 5'd12, 5'd13);              // ALU favored.
    issue_alu(OP_XOR, 5'd9, 5'd4, 5'd4, SEW_32);
    issue_load(5'd7, SEW_32, 32'h8877_6655, 32'h4433_2211);
    issue_load(5'd7, SEW_16, 32'hdead_bbaa, 32'hbeef_9900);
    issue_load(5'd7, SEW_8, 32'h1234_56cc, 32'h0000_00dd);
    issue_alu(OP_AND, 5'd10, 5'd7, 5'd7, SEW_32);  // Upper bytes survive.
    issue_alu(OP_XOR, 5'd11, 5'd7, 5'd7, SEW_16);
    issue_load(5'd1, SEW_32, 32'hffff_ff80, 32'hffff_fff0);
    issue_load(5'd2, SEW_32, 32'h0000_0081, 32'h0000_0021);
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        issue_alu(valu_op_t'(o[1:0]), 5'd3, 5'd1, 5'd2, sew_t'(s[1:0]));
        issue_alu(valu_op_t'(o[1:0]), 5'd4, 5'd2, 5'd1, sew_t'(s[1:0]));
      end
    end
    issue_alu(OP_SUB, 5'd14, 5'd1, 5'd2, SEW_8);
    issue_both(OP_XOR, 5'd15, 5'd12);              // Load's turn.
    issue_both(OP_AND, 5'd13, 5'd15);
    run_random(RAND_OPS);
    idle(4);                                       // Drain.
    if ((alu_q.size() == 0) && (load_q.size() == 0)) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("Expected writes were never committed by the end of the run");
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
design/vec_types_pkg.sv
design/valu_ops_pkg.sv
design/vec_reg_file.sv
design/vec_wb_arbiter.sv
design/vec_alu_unit.sv
design/vec_load_unit.sv
design/vec_lane_top.sv
tests/vec_lane_tb.sv
